// File: bench/rtc_display_properties.sv
module rtc_display_properties
#(
	parameter int credits = 4
)
(
	input logic                             clk,
	input logic                             arst_n,
	input logic [$clog2(credits + 1)-1:0]   credit_cnt,
	input logic                             frame_req,
	input logic                             credit_return,
	input logic                             glyph_valid,
	input logic                             frame_busy,
	input logic                             frame_done
);

	timeunit 1ns;
	timeprecision 1ps;

	int   fail_count = 0;
	int   credits_left;
	logic in_frame;

	// Credits still held by the streamer, counted from the glyphs sent and the
	// credits handed back by the sink.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			credits_left <= credits;
		else
			credits_left <= credits_left - (glyph_valid ? 1 : 0) + (credit_return ? 1 : 0);
	end

	// A frame opens on a request taken while idle or on the closing cycle,
	// and it closes when frame_done is seen.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			in_frame <= 1'b0;
		else if (frame_req && (!in_frame || frame_done))
			in_frame <= 1'b1;
		else if (frame_done)
			in_frame <= 1'b0;
	end

	// ==================================================
	// Credit accounting.
	// ==================================================

	// The sink can never hand back more credits than the streamer started with.
	credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credit_cnt <= credits)
		else
		begin
			$error("Credit count %0d is above the limit %0d", credit_cnt, credits);
			fail_count++;
		end

	credit_spent: assert property (@(posedge clk) disable iff (!arst_n)
		glyph_valid |-> (credits_left > 0))
		else
		begin
			$error("Glyph sent with no credit left");
			fail_count++;
		end

	// ==================================================
	// Glyph stream framing.
	// ==================================================

	valid_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		(glyph_valid || frame_busy) |-> (in_frame && !frame_done))
		else
		begin
			$error("Glyph sent outside a frame");
			fail_count++;
		end

	done_single: assert property (@(posedge clk) disable iff (!arst_n)
		frame_done |=> !frame_done)
		else
		begin
			$error("frame_done held for more than one cycle");
			fail_count++;
		end

endmodule

// File: bench/rtc_display_tb.sv
module rtc_display_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import clock_pkg::*;

	localparam int credits    = 4;
	localparam int wait_limit = 400;

	logic         clk;
	logic         arst_n;
	logic         tick_1hz;
	logic         set_valid;
	rtc_set_t     set_value;
	logic         mode_12h;
	logic         frame_req;
	logic         credit_return;
	logic         glyph_valid;
	glyph_u       glyph;
	logic         frame_busy;
	logic         frame_done;

	// Test table, one entry per row in every queue.
	string        names[$];
	logic         load_flags[$];
	logic         mode_flags[$];
	int           tick_counts[$];
	rtc_set_t     loads[$];
	glyph_frame_t expects[$];

	int           errors = 0;
	int           failed_tests = 0;
	int           prop_fails = 0;
	logic [31:0]  lfsr_state = 32'hee13_b61f;
	int           pending[$];
	int           cyc = 0;

	rtc_display_top #(
		.credits (credits)
	) u_rtc_display_top
	(
		.clk           (clk),
		.arst_n        (arst_n),
		.tick_1hz      (tick_1hz),
		.set_valid     (set_valid),
		.set_value     (set_value),
		.mode_12h      (mode_12h),
		.frame_req     (frame_req),
		.credit_return (credit_return),
		.glyph_valid   (glyph_valid),
		.glyph         (glyph),
		.frame_busy    (frame_busy),
		.frame_done    (frame_done)
	);

	bind glyph_streamer rtc_display_properties #(
		.credits (credits)
	) u_stream_props
	(
		.clk           (clk),
		.arst_n        (arst_n),
		.credit_cnt    (credit_cnt),
		.frame_req     (frame_req),
		.credit_return (credit_return),
		.glyph_valid   (glyph_valid),
		.frame_busy    (frame_busy),
		.frame_done    (frame_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==================================================
	// Helpers for the table.
	// ==================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		else
			return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output int v);
		int k;
		v = 0;
		for (k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic rtc_set_t make_set(input logic [15:0] yr, input logic [7:0] mo,
		input logic [7:0] dy, input logic [7:0] hh, input logic [7:0] mm, input logic [7:0] ss);
		rtc_set_t s;
		s.dt.year   = yr;
		s.dt.month  = mo;
		s.dt.day    = dy;
		s.tm.hour   = hh;
		s.tm.minute = mm;
		s.tm.second = ss;
		return s;
	endfunction

	// Digits go into slots 15 down to 0, and the two letters fill slots 7 and 6.
	function automatic glyph_frame_t build_frame(input logic [15:0] yr, input logic [7:0] mo,
		input logic [7:0] dy, input logic [5:0] l1, input logic [5:0] l0,
		input logic [7:0] hh, input logic [7:0] mm, input logic [7:0] ss);
		glyph_frame_t f;
		logic [63:0]  nib;
		int           k;
		nib = {yr, mo, dy, 8'h00, hh, mm, ss};
		for (k = 0; k < frame_slots; k++)
			f[k].code = {2'b00, nib[4*k +: 4]};
		f[7].code = l1;
		f[6].code = l0;
		return f;
	endfunction

	task automatic add_row(input string name, input logic ld, input logic m12, input int nt,
		input rtc_set_t s, input glyph_frame_t e);
		names.push_back(name);
		load_flags.push_back(ld);
		mode_flags.push_back(m12);
		tick_counts.push_back(nt);
		loads.push_back(s);
		expects.push_back(e);
	endtask

	task automatic hour_row(input logic m12, input logic [7:0] hh, input logic [7:0] shown,
		input logic pm);
		logic [5:0] first_letter;
		logic [5:0] second_letter;
		string      name;
		first_letter  = m12 ? (pm ? font_p : font_a) : font_none;
		second_letter = m12 ? font_m : font_none;
		name = $sformatf("%s_hour_%h", m12 ? "h12" : "h24", hh);
		add_row(name, 1'b1, m12, 0, make_set(16'h2024, 8'h06, 8'h15, hh, 8'h30, 8'h45),
			build_frame(16'h2024, 8'h06, 8'h15, first_letter, second_letter, shown, 8'h30, 8'h45));
	endtask

	task automatic build_table();
		logic [7:0] hour_list [8];
		int         k;
		hour_list = '{8'h00, 8'h09, 8'h12, 8'h13, 8'h19, 8'h20, 8'h21, 8'h22};
		// The first row runs straight out of reset with nothing loaded.
		add_row("reset_default", 1'b0, 1'b1, 0, make_set(16'h0, 8'h0, 8'h0, 8'h0, 8'h0, 8'h0),
			build_frame(16'h2000, 8'h01, 8'h01, font_a, font_m, 8'h12, 8'h00, 8'h00));
		add_row("year_rollover", 1'b1, 1'b0, 1, make_set(16'h2023, 8'h12, 8'h31, 8'h23, 8'h59, 8'h59),
			build_frame(16'h2024, 8'h01, 8'h01, font_none, font_none, 8'h00, 8'h00, 8'h00));
		add_row("carry_to_hour", 1'b1, 1'b0, 3, make_set(16'h2023, 8'h05, 8'h05, 8'h09, 8'h59, 8'h58),
			build_frame(16'h2023, 8'h05, 8'h05, font_none, font_none, 8'h10, 8'h00, 8'h01));
		add_row("leap_2024", 1'b1, 1'b0, 1, make_set(16'h2024, 8'h02, 8'h28, 8'h23, 8'h59, 8'h59),
			build_frame(16'h2024, 8'h02, 8'h29, font_none, font_none, 8'h00, 8'h00, 8'h00));
		add_row("common_2023", 1'b1, 1'b0, 1, make_set(16'h2023, 8'h02, 8'h28, 8'h23, 8'h59, 8'h59),
			build_frame(16'h2023, 8'h03, 8'h01, font_none, font_none, 8'h00, 8'h00, 8'h00));
		add_row("century_2100", 1'b1, 1'b0, 1, make_set(16'h2100, 8'h02, 8'h28, 8'h23, 8'h59, 8'h59),
			build_frame(16'h2100, 8'h03, 8'h01, font_none, font_none, 8'h00, 8'h00, 8'h00));
		add_row("leap_2000", 1'b1, 1'b0, 1, make_set(16'h2000, 8'h02, 8'h28, 8'h23, 8'h59, 8'h59),
			build_frame(16'h2000, 8'h02, 8'h29, font_none, font_none, 8'h00, 8'h00, 8'h00));
		add_row("april_end", 1'b1, 1'b1, 1, make_set(16'h2024, 8'h04, 8'h30, 8'h23, 8'h59, 8'h59),
			build_frame(16'h2024, 8'h05, 8'h01, font_a, font_m, 8'h12, 8'h00, 8'h00));
		hour_row(1'b1, 8'h00, 8'h12, 1'b0);
		hour_row(1'b1, 8'h09, 8'h09, 1'b0);
		hour_row(1'b1, 8'h12, 8'h12, 1'b1);
		hour_row(1'b1, 8'h13, 8'h01, 1'b1);
		hour_row(1'b1, 8'h19, 8'h07, 1'b1);
		hour_row(1'b1, 8'h20, 8'h08, 1'b1);
		hour_row(1'b1, 8'h21, 8'h09, 1'b1);
		hour_row(1'b1, 8'h22, 8'h10, 1'b1);
		for (k = 0; k < 8; k++)
			hour_row(1'b0, hour_list[k], hour_list[k], 1'b0);
	endtask

	// ==================================================
	// Running one row.
	// ==================================================

	task automatic run_row(input int i);
		int           got;
		int           dones;
		int           waited;
		int           extra;
		int           err_before;
		int           new_fails;
		int           t;
		glyph_frame_t e;
		glyph_u       expected;
		err_before = errors;
		e = expects[i];
		@(posedge clk);
		#1;
		mode_12h  = mode_flags[i];
		set_valid = load_flags[i];
		set_value = loads[i];
		@(posedge clk);
		#1;
		set_valid = 1'b0;
		for (t = 0; t < tick_counts[i]; t++)
		begin
			tick_1hz = 1'b1;
			@(posedge clk);
			#1;
			tick_1hz = 1'b0;
			repeat (2) @(posedge clk);
			#1;
		end
		frame_req = 1'b1;
		got = 0;
		dones = 0;
		waited = 0;
		while ((got < frame_slots || dones == 0) && waited < wait_limit)
		begin
			@(posedge clk);
			#1;
			// A second request in the middle of the frame must be ignored.
			frame_req = (got == 4);
			@(negedge clk);
			waited++;
			if (glyph_valid)
			begin
				assert (got < frame_slots)
				else
				begin
					$display("Test %s sent more than sixteen glyphs", names[i]);
					errors++;
				end
				if (got < frame_slots)
				begin
					expected = e[frame_slots - 1 - got];
					assert (glyph === expected)
					else
					begin
						$display("FAILED %s slot %0d: expected %h, actual %h", names[i],
							frame_slots - 1 - got, expected, glyph);
						errors++;
					end
				end
				got++;
			end
			if (frame_done)
			begin
				dones++;
				assert (got == frame_slots)
				else
				begin
					$display("Test %s saw frame_done after only %0d glyphs", names[i], got);
					errors++;
				end
			end
		end
		frame_req = 1'b0;
		assert (got == frame_slots && dones == 1)
		else
		begin
			$display("Test %s timed out waiting for the frame, %0d glyphs seen", names[i], got);
			errors++;
		end
		// Nothing more may come out once the frame is done.
		extra = 0;
		repeat (20)
		begin
			@(negedge clk);
			if (glyph_valid || frame_done)
				extra++;
		end
		assert (extra == 0 && !frame_busy)
		else
		begin
			$display("Test %s kept streaming after frame_done", names[i]);
			errors++;
		end
		new_fails = u_rtc_display_top.u_glyph_streamer.u_stream_props.fail_count - prop_fails;
		if (new_fails != 0)
		begin
			$display("Test %s broke %0d stream assertions", names[i], new_fails);
			errors += new_fails;
			prop_fails += new_fails;
		end
		if (errors != err_before)
			failed_tests++;
		$display("%-16s %s", names[i], (errors == err_before) ? "passed" : "failed");
	endtask

	// Display sink, returning each credit 0 to 7 cycles after its glyph.
	initial
	begin
		int delay;
		credit_return = 1'b0;
		forever
		begin
			@(negedge clk);
			if (glyph_valid)
			begin
				draw_bits(3, delay);
				pending.push_back(cyc + delay);
			end
			@(posedge clk);
			#1;
			cyc++;
			if (pending.size() > 0 && pending[0] <= cyc)
			begin
				credit_return = 1'b1;
				void'(pending.pop_front());
			end
			else
				credit_return = 1'b0;
		end
	end

	initial
	begin
		int i;
		arst_n    = 1'b1;
		tick_1hz  = 1'b0;
		set_valid = 1'b0;
		set_value = '0;
		mode_12h  = 1'b0;
		frame_req = 1'b0;
		#1;
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		build_table();
		for (i = 0; i < names.size(); i++)
			run_row(i);
		$display("Summary: %0d tests, %0d failed, %0d errors", names.size(), failed_tests, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
hw/clock_pkg.sv
hw/time_counter.sv
hw/date_counter.sv
hw/display_ctl.sv
hw/glyph_streamer.sv
hw/rtc_display_top.sv
bench/rtc_display_properties.sv
bench/rtc_display_tb.sv

// File: hw/clock_pkg.sv
package clock_pkg;

	// ==================================================
	// Time and date words, all held in packed BCD.
	// ==================================================

	typedef struct packed {
		logic [7:0] hour;
		logic [7:0] minute;
		logic [7:0] second;
	} bcd_time_t;

	typedef struct packed {
		logic [15:0] year;
		logic [7:0]  month;
		logic [7:0]  day;
	} bcd_date_t;

	typedef struct packed {
		bcd_time_t tm;
		bcd_date_t dt;
	} rtc_set_t;

	// The calendar comes out of reset on the first day of 2000.
	localparam bcd_date_t date_at_reset = '{year: 16'h2000, month: 8'h01, day: 8'h01};

	// ==================================================
	// Display glyphs.
	// ==================================================

	// A digit glyph carries a zero tag, so every letter code has a nonzero tag.
	localparam logic [1:0] digit_tag = 2'b00;

	typedef struct packed {
		logic [1:0] tag;
		logic [3:0] bcd;
	} glyph_digit_t;

	typedef union packed {
		glyph_digit_t digit;
		logic [5:0]   code;
	} glyph_u;

	localparam logic [5:0] font_a    = 6'b01_0000;
	localparam logic [5:0] font_m    = 6'b01_0001;
	localparam logic [5:0] font_p    = 6'b01_0010;
	localparam logic [5:0] font_none = 6'b11_1111;

	localparam int frame_slots = 16;

	// Slot 15 is the leading year digit, slot 0 the units of the seconds.
	typedef glyph_u [frame_slots-1:0] glyph_frame_t;

	function automatic glyph_u make_digit(input logic [3:0] bcd);
		glyph_u g;
		g.digit.tag = digit_tag;
		g.digit.bcd = bcd;
		return g;
	endfunction

	// Mod-100 increment of a two-digit BCD pair, so 99 rolls over to 00.
	function automatic logic [7:0] bcd_inc8(input logic [7:0] v);
		logic [7:0] r;
		r = v;
		if (v[3:0] == 4'd9)
		begin
			r[3:0] = 4'd0;
			r[7:4] = (v[7:4] == 4'd9) ? 4'd0 : v[7:4] + 4'd1;
		end
		else
			r[3:0] = v[3:0] + 4'd1;
		return r;
	endfunction

endpackage

// File: hw/date_counter.sv
module date_counter
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 advance,
	input  logic                 load,
	input  clock_pkg::bcd_date_t load_date,
	output clock_pkg::bcd_date_t cur_date
);

	import clock_pkg::*;

	logic       leap_year;
	logic [7:0] last_day;
	bcd_date_t  next_date;

	// A two-digit BCD number divides by 4 when an even tens digit meets
	// units of 0, 4 or 8, or an odd tens digit meets units of 2 or 6.
	function automatic logic bcd_div4(input logic [7:0] v);
		logic odd_tens;
		odd_tens = v[4];
		if (odd_tens)
			return (v[3:0] == 4'd2) || (v[3:0] == 4'd6);
		else
			return (v[3:0] == 4'd0) || (v[3:0] == 4'd4) || (v[3:0] == 4'd8);
	endfunction

	// ==================================================
	// Leap year and month length.
	// ==================================================

	// For a century year the test moves to the upper pair, which is the
	// same as asking whether the whole year divides by 400.
	always_comb
	begin
		if (cur_date.year[7:0] == 8'h00)
			leap_year = bcd_div4(cur_date.year[15:8]);
		else
			leap_year = bcd_div4(cur_date.year[7:0]);
	end

	always_comb
	begin
		case (cur_date.month)
			8'h02:
				last_day = leap_year ? 8'h29 : 8'h28;
			8'h04, 8'h06, 8'h09, 8'h11:
				last_day = 8'h30;
			default:
				last_day = 8'h31;
		endcase
	end

	// ==================================================
	// Next date on a day carry.
	// ==================================================

	always_comb
	begin
		next_date = cur_date;
		if (cur_date.day == last_day)
		begin
			next_date.day = 8'h01;
			if (cur_date.month == 8'h12)
			begin
				next_date.month = 8'h01;
				// The year is two cascaded pairs, so 9999 rolls over to 0000.
				next_date.year[7:0] = bcd_inc8(cur_date.year[7:0]);
				if (cur_date.year[7:0] == 8'h99)
					next_date.year[15:8] = bcd_inc8(cur_date.year[15:8]);
			end
			else
				next_date.month = bcd_inc8(cur_date.month);
		end
		else
			next_date.day = bcd_inc8(cur_date.day);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cur_date <= date_at_reset;
		else if (load)
			cur_date <= load_date;
		else if (advance)
			cur_date <= next_date;
	end

endmodule

// File: hw/display_ctl.sv
module display_ctl
(
	input  logic                    mode_12h,
	input  clock_pkg::bcd_time_t    cur_time,
	input  clock_pkg::bcd_date_t    cur_date,
	output clock_pkg::glyph_frame_t frame
);

	import clock_pkg::*;

	logic [3:0] hour_tens;
	logic [3:0] hour_units;
	logic       is_pm;

	// BCD words order the same way as the numbers they hold.
	assign is_pm = (cur_time.hour >= 8'h12);

	// ==================================================
	// Hour rewrite for 12-hour mode.
	// ==================================================

	always_comb
	begin
		hour_tens  = cur_time.hour[7:4];
		hour_units = cur_time.hour[3:0];
		if (mode_12h)
		begin
			if (cur_time.hour == 8'h00)
			begin
				hour_tens  = 4'd1;
				hour_units = 4'd2;
			end
			else if ((cur_time.hour > 8'h12) && (cur_time.hour < 8'h20))
			begin
				hour_tens  = cur_time.hour[7:4] - 4'd1;
				hour_units = cur_time.hour[3:0] - 4'd2;
			end
			else if ((cur_time.hour == 8'h20) || (cur_time.hour == 8'h21))
			begin
				// Subtracting 12 here borrows across the tens boundary.
				hour_tens  = cur_time.hour[7:4] - 4'd2;
				hour_units = cur_time.hour[3:0] + 4'd8;
			end
			else if (cur_time.hour >= 8'h22)
			begin
				hour_tens  = cur_time.hour[7:4] - 4'd1;
				hour_units = cur_time.hour[3:0] - 4'd2;
			end
		end
	end

	// ==================================================
	// Frame assembly.
	// ==================================================

	always_comb
	begin
		frame[15] = make_digit(cur_date.year[15:12]);
		frame[14] = make_digit(cur_date.year[11:8]);
		frame[13] = make_digit(cur_date.year[7:4]);
		frame[12] = make_digit(cur_date.year[3:0]);
		frame[11] = make_digit(cur_date.month[7:4]);
		frame[10] = make_digit(cur_date.month[3:0]);
		frame[9]  = make_digit(cur_date.day[7:4]);
		frame[8]  = make_digit(cur_date.day[3:0]);
		// The letter pair reads AM or PM, or stays blank in 24-hour mode.
		frame[7].code = mode_12h ? (is_pm ? font_p : font_a) : font_none;
		frame[6].code = mode_12h ? font_m : font_none;
		frame[5]  = make_digit(hour_tens);
		frame[4]  = make_digit(hour_units);
		frame[3]  = make_digit(cur_time.minute[7:4]);
		frame[2]  = make_digit(cur_time.minute[3:0]);
		frame[1]  = make_digit(cur_time.second[7:4]);
		frame[0]  = make_digit(cur_time.second[3:0]);
	end

endmodule

// File: hw/glyph_streamer.sv
module glyph_streamer
#(
	parameter int credits = 4
)
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  clock_pkg::glyph_frame_t frame,
	input  logic                    frame_req,
	input  logic                    credit_return,
	output logic                    glyph_valid,
	output clock_pkg::glyph_u       glyph,
	output logic                    frame_busy,
	output logic                    frame_done
);

	import clock_pkg::*;

	localparam int credit_w = $clog2(credits + 1);
	localparam int slot_w   = $clog2(frame_slots);

	glyph_frame_t        snap;
	logic [slot_w-1:0]   slot;
	logic [credit_w-1:0] credit_cnt;
	logic                start;
	logic                send;

	// A request is taken only while no frame is in flight.
	assign start = frame_req && !frame_busy;

	// One glyph leaves in every busy cycle that still holds a credit.
	assign send        = frame_busy && (credit_cnt != '0);
	assign glyph_valid = send;
	assign glyph       = snap[slot];

	// ==================================================
	// Snapshot and slot sequencing.
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (start)
			snap <= frame;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			frame_busy <= 1'b0;
			frame_done <= 1'b0;
			slot       <= '0;
		end
		else
		begin
			frame_done <= send && (slot == '0);
			if (start)
			begin
				frame_busy <= 1'b1;
				slot       <= slot_w'(frame_slots - 1);
			end
			else if (send)
			begin
				if (slot == '0)
					frame_busy <= 1'b0;
				else
					slot <= slot - 1'b1;
			end
		end
	end

	// ==================================================
	// Credit counter.
	// ==================================================

	// A spend and a return in the same cycle cancel out.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			credit_cnt <= credit_w'(credits);
		else
		begin
			case ({send, credit_return})
				2'b10:
					credit_cnt <= credit_cnt - 1'b1;
				2'b01:
					credit_cnt <= credit_cnt + 1'b1;
				default:
					credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

// File: hw/rtc_display_top.sv
module rtc_display_top
#(
	parameter int credits = 4
)
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                tick_1hz,
	input  logic                set_valid,
	input  clock_pkg::rtc_set_t set_value,
	input  logic                mode_12h,
	input  logic                frame_req,
	input  logic                credit_return,
	output logic                glyph_valid,
	output clock_pkg::glyph_u   glyph,
	output logic                frame_busy,
	output logic                frame_done
);

	import clock_pkg::*;

	bcd_time_t    cur_time;
	bcd_date_t    cur_date;
	glyph_frame_t frame;
	logic         day_carry;

	// One load writes both counters, each taking its own half of set_value.
	time_counter u_time_counter
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.tick      (tick_1hz),
		.load      (set_valid),
		.load_time (set_value.tm),
		.cur_time  (cur_time),
		.day_carry (day_carry)
	);

	date_counter u_date_counter
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.advance   (day_carry),
		.load      (set_valid),
		.load_date (set_value.dt),
		.cur_date  (cur_date)
	);

	display_ctl u_display_ctl
	(
		.mode_12h (mode_12h),
		.cur_time (cur_time),
		.cur_date (cur_date),
		.frame    (frame)
	);

	glyph_streamer #(
		.credits (credits)
	) u_glyph_streamer
	(
		.clk           (clk),
		.arst_n        (arst_n),
		.frame         (frame),
		.frame_req     (frame_req),
		.credit_return (credit_return),
		.glyph_valid   (glyph_valid),
		.glyph         (glyph),
		.frame_busy    (frame_busy),
		.frame_done    (frame_done)
	);

endmodule

// File: hw/time_counter.sv
module time_counter
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 tick,
	input  logic                 load,
	input  clock_pkg::bcd_time_t load_time,
	output clock_pkg::bcd_time_t cur_time,
	output logic                 day_carry
);

	import clock_pkg::*;

	logic      sec_wrap;
	logic      min_wrap;
	logic      hour_wrap;
	bcd_time_t next_time;

	// ==================================================
	// Wrap detection and the day carry.
	// ==================================================

	assign sec_wrap  = (cur_time.second == 8'h59);
	assign min_wrap  = (cur_time.minute == 8'h59);
	assign hour_wrap = (cur_time.hour == 8'h23);

	// The date counter steps on the same edge as the wrap to midnight.
	assign day_carry = tick && sec_wrap && min_wrap && hour_wrap;

	// ==================================================
	// Next count on a tick.
	// ==================================================

	// Each pair handles its own units-to-tens carry inside bcd_inc8.
	always_comb
	begin
		next_time = cur_time;
		if (sec_wrap)
		begin
			next_time.second = 8'h00;
			if (min_wrap)
			begin
				next_time.minute = 8'h00;
				if (hour_wrap)
					next_time.hour = 8'h00;
				else
					next_time.hour = bcd_inc8(cur_time.hour);
			end
			else
				next_time.minute = bcd_inc8(cur_time.minute);
		end
		else
			next_time.second = bcd_inc8(cur_time.second);
	end

	// A load wins over a tick in the same cycle.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cur_time <= '0;
		else if (load)
			cur_time <= load_time;
		else if (tick)
			cur_time <= next_time;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the calendar clock display testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module rtc_display_tb -f filelist.f -o sim_rtc_display
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_rtc_display)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
